// File: common/stat_macros.svh
`ifndef STAT_MACROS_SVH
`define STAT_MACROS_SVH

////////////////////////////////
// Stream geometry
////////////////////////////////

// 32-bit words carried by one beat
`define STAT_LANES      16
`define STAT_WORD_W     32

////////////////////////////////
// Register port
////////////////////////////////

// Wishbone byte address width
`define STAT_ADR_W      8

`define STAT_REG_CTRL   8'h00
`define STAT_REG_STATUS 8'h04
`define STAT_REG_MIN    8'h08
`define STAT_REG_MAX    8'h0C
`define STAT_REG_COUNT  8'h10

`endif

// File: common/stat_pkg.sv
`include "stat_macros.svh"

package stat_pkg;

    ////////////////////////////////
    // Scalar types
    ////////////////////////////////

    typedef logic [`STAT_WORD_W-1:0] word_t;
    typedef logic [31:0]             count_t;
    typedef logic [`STAT_ADR_W-1:0]  wb_adr_t;

    ////////////////////////////////
    // Stream and result records
    ////////////////////////////////

    // One beat of the input stream, 514 bits
    typedef struct packed {
        logic                     valid;
        logic                     last;
        word_t [`STAT_LANES-1:0]  data;
    } beat_t;

    // Extremes of one beat leaving the compare tree
    typedef struct packed {
        logic  valid;
        logic  last;
        word_t min;
        word_t max;
    } reduced_t;

    // Register bank as seen by the decoder
    typedef struct packed {
        word_t  min;
        word_t  max;
        count_t count;
        logic   done;
    } stat_regs_t;

endpackage

// File: minmax/minmax_tree.sv
`include "stat_macros.svh"

module minmax_tree
    import stat_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,

    input  beat_t    stream,
    output reduced_t reduced
);

// Halving stages needed to bring all lanes down to one candidate
localparam int STAGES = $clog2(`STAT_LANES);

// Stage 0 is the registered beat, stage s holds LANES >> s candidates
word_t [`STAT_LANES-1:0] min_s [STAGES+1];
word_t [`STAT_LANES-1:0] max_s [STAGES+1];

logic [STAGES:0] valid_s;
logic [STAGES:0] last_s;

function automatic word_t min_of(input word_t a, input word_t b);
    return (a < b) ? a : b;
endfunction

function automatic word_t max_of(input word_t a, input word_t b);
    return (a > b) ? a : b;
endfunction

////////////////////////////////
// Sideband pipe
////////////////////////////////

always_ff @(posedge aclk) begin
    if (!aresetn) begin
        valid_s <= '0;
    end else begin
        valid_s <= {valid_s[STAGES-1:0], stream.valid};
    end
    last_s <= {last_s[STAGES-1:0], stream.last};
end

////////////////////////////////
// Compare tree
////////////////////////////////

always_ff @(posedge aclk) begin
    min_s[0] <= stream.data;
    max_s[0] <= stream.data;

    // Lane i meets lane i + half, both paths in parallel
    for (int s = 1; s <= STAGES; s++) begin
        for (int i = 0; i < (`STAT_LANES >> s); i++) begin
            min_s[s][i] <= min_of(min_s[s-1][i],
                                  min_s[s-1][i + (`STAT_LANES >> s)]);
            max_s[s][i] <= max_of(max_s[s-1][i],
                                  max_s[s-1][i + (`STAT_LANES >> s)]);
        end
    end
end

////////////////////////////////
// Output register
////////////////////////////////

always_ff @(posedge aclk) begin
    if (!aresetn) begin
        reduced.valid <= 1'b0;
    end else begin
        reduced.valid <= valid_s[STAGES];
    end
    reduced.last <= last_s[STAGES];
    reduced.min  <= min_s[STAGES][0];
    reduced.max  <= max_s[STAGES][0];
end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status carries the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sources.f --top-module stream_stat_tb -o stream_stat_sim

./obj_dir/stream_stat_sim

// File: source/csr_decode.sv
`include "stat_macros.svh"

module csr_decode
    import stat_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,

    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  wb_adr_t    wb_adr,
    input  word_t      wb_dat_w,
    output word_t      wb_dat_r,
    output logic       wb_ack,

    input  stat_regs_t regs,
    output logic       clear
);

logic  req;
word_t rd_data;

// New request only when no ack is pending for this strobe
assign req = wb_cyc && wb_stb && !wb_ack;

////////////////////////////////
// Read mux
////////////////////////////////

always_comb begin
    case (wb_adr)
        `STAT_REG_STATUS: rd_data = word_t'(regs.done);
        `STAT_REG_MIN:    rd_data = regs.min;
        `STAT_REG_MAX:    rd_data = regs.max;
        `STAT_REG_COUNT:  rd_data = word_t'(regs.count);
        // CTRL and unmapped offsets
        default:          rd_data = '0;
    endcase
end

////////////////////////////////
// Ack and control
////////////////////////////////

always_ff @(posedge aclk) begin
    if (!aresetn) begin
        wb_ack <= 1'b0;
        clear  <= 1'b0;
    end else begin
        wb_ack <= req;
        clear  <= req && wb_we && (wb_adr == `STAT_REG_CTRL) && wb_dat_w[0];
    end
end

// Read data lands together with the ack
always_ff @(posedge aclk) begin
    if (req && !wb_we) begin
        wb_dat_r <= rd_data;
    end
end

endmodule

// File: source/stat_result.sv
module stat_result
    import stat_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,

    input  reduced_t   reduced,
    input  logic       clear,

    output stat_regs_t regs,
    output logic       done
);

// Minimum starts from all ones so the first beat always wins
localparam stat_regs_t REGS_INIT = '{
    min:   '1,
    max:   '0,
    count: '0,
    done:  1'b0
};

logic frame_end;

assign frame_end = reduced.valid && reduced.last;

////////////////////////////////
// Accumulators
////////////////////////////////

always_ff @(posedge aclk) begin
    if (!aresetn) begin
        regs <= REGS_INIT;
        done <= 1'b0;
    end else if (clear) begin
        // Clear beats any update on the same edge
        regs <= REGS_INIT;
        done <= 1'b0;
    end else begin
        done <= frame_end;
        if (reduced.valid) begin
            if (reduced.min < regs.min) begin
                regs.min <= reduced.min;
            end
            if (reduced.max > regs.max) begin
                regs.max <= reduced.max;
            end
            regs.count <= regs.count + count_t'(1);
        end
        // Sticky until software clears it
        if (frame_end) begin
            regs.done <= 1'b1;
        end
    end
end

endmodule

// File: source/stream_stat_top.sv
module stream_stat_top
    import stat_pkg::*;
(
    input  logic    aclk,
    input  logic    aresetn,

    input  beat_t   stream,
    output logic    stream_ready,

    input  logic    wb_cyc,
    input  logic    wb_stb,
    input  logic    wb_we,
    input  wb_adr_t wb_adr,
    input  word_t   wb_dat_w,
    output word_t   wb_dat_r,
    output logic    wb_ack,

    output logic    done
);

reduced_t   reduced;
stat_regs_t regs;
logic       clear;

// No back-pressure, ready just tracks reset
always_ff @(posedge aclk) begin
    stream_ready <= aresetn;
end

minmax_tree minmax_tree_inst (
    .aclk    (aclk),
    .aresetn (aresetn),
    .stream  (stream),
    .reduced (reduced)
);

csr_decode csr_decode_inst (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .regs     (regs),
    .clear    (clear)
);

stat_result stat_result_inst (
    .aclk    (aclk),
    .aresetn (aresetn),
    .reduced (reduced),
    .clear   (clear),
    .regs    (regs),
    .done    (done)
);

endmodule

// File: sources.f
+incdir+common
common/stat_pkg.sv
minmax/minmax_tree.sv
source/csr_decode.sv
source/stat_result.sv
source/stream_stat_top.sv
tests/stream_stat_asserts.sv
tests/stream_stat_tb.sv

// File: tests/stream_stat_asserts.sv
module stream_stat_asserts
    import stat_pkg::*;
(
    input logic  aclk,
    input logic  aresetn,
    input beat_t stream,
    input logic  wb_cyc,
    input logic  wb_stb,
    input logic  wb_ack,
    input logic  done
);

timeunit 1ns;
timeprecision 100ps;

logic frame_end;

assign frame_end = stream.valid && stream.last;

//////////////////////////////
// Wishbone handshake
//////////////////////////////

ack_one_cycle: assert property (@(posedge aclk) disable iff (!aresetn)
    wb_ack |=> !wb_ack)
    else $error("wb_ack stayed high for more than one cycle");

ack_needs_strobe: assert property (@(posedge aclk) disable iff (!aresetn)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack without a held strobe");

ack_after_strobe: assert property (@(posedge aclk) disable iff (!aresetn)
    $rose(wb_cyc && wb_stb) |=> wb_ack)
    else $error("wb_ack missing one cycle after the strobe");

//////////////////////////////
// Done latency
//////////////////////////////

// Done is written on the sixth edge after the accepting edge,
// so sampled values see it one tick later
done_after_last: assert property (@(posedge aclk) disable iff (!aresetn)
    $past(frame_end, 7) |-> done)
    else $error("done missing six cycles after a last beat");

done_only_after_last: assert property (@(posedge aclk) disable iff (!aresetn)
    done |-> $past(frame_end, 7))
    else $error("done without a last beat six cycles earlier");

endmodule

bind stream_stat_top stream_stat_asserts stream_stat_asserts_inst (
    .aclk    (aclk),
    .aresetn (aresetn),
    .stream  (stream),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .done    (done)
);

// File: tests/stream_stat_tb.sv
`include "stat_macros.svh"

module stream_stat_tb
    import stat_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

localparam int WAIT_LIMIT = 50;

logic    aclk;
logic    aresetn;
beat_t   stream;
logic    stream_ready;
logic    wb_cyc;
logic    wb_stb;
logic    wb_we;
wb_adr_t wb_adr;
word_t   wb_dat_w;
word_t   wb_dat_r;
logic    wb_ack;
logic    done;

logic [31:0] lcg_state = 32'h5b18dd2b;

// Reference statistics since the last clear
word_t  model_min;
word_t  model_max;
count_t model_count;

stream_stat_top stream_stat_top_inst (.*);

initial begin
    aclk = 1'b0;
    forever begin
        #2 aclk = ~aclk;
    end
end

function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

task automatic stop_with_failure();
    $display("Verification failed");
    $fatal(1, "simulation stopped on error");
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
        $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, exp);
        stop_with_failure();
    end
endtask

task automatic model_clear();
    model_min   = '1;
    model_max   = '0;
    model_count = '0;
endtask

//////////////////////////////
// Wishbone master
//////////////////////////////

task automatic wb_access(input logic we, input wb_adr_t adr, input word_t wdata,
                         output word_t rdata);
    int cycles;
    cycles   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    do begin
        @(posedge aclk);
        #1;
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            $display("Timeout waiting for wb_ack at offset %h", adr);
            stop_with_failure();
        end
    end while (!wb_ack);
    check_word("wb_ack latency", word_t'(cycles), 32'd1);
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    // Idle cycle between transfers
    @(posedge aclk);
    #1;
endtask

task automatic wb_write(input wb_adr_t adr, input word_t data);
    word_t ignored;
    wb_access(1'b1, adr, data, ignored);
endtask

task automatic check_reg(input string name, input wb_adr_t adr, input word_t exp);
    word_t got;
    wb_access(1'b0, adr, '0, got);
    check_word(name, got, exp);
endtask

task automatic check_stats(input logic exp_done);
    check_reg("STATUS", `STAT_REG_STATUS, word_t'(exp_done));
    check_reg("MIN", `STAT_REG_MIN, model_min);
    check_reg("MAX", `STAT_REG_MAX, model_max);
    check_reg("COUNT", `STAT_REG_COUNT, model_count);
endtask

//////////////////////////////
// Stream source
//////////////////////////////

task automatic send_beat(input word_t [`STAT_LANES-1:0] data, input logic last);
    stream.valid = 1'b1;
    stream.last  = last;
    stream.data  = data;
    for (int i = 0; i < `STAT_LANES; i++) begin
        if (data[i] < model_min) begin
            model_min = data[i];
        end
        if (data[i] > model_max) begin
            model_max = data[i];
        end
    end
    model_count = model_count + 32'd1;
    @(posedge aclk);
    #1;
    stream.valid = 1'b0;
    stream.last  = 1'b0;
endtask

// Beats go out back to back, one per cycle
task automatic send_random_frame(input int beats);
    word_t [`STAT_LANES-1:0] data;
    for (int b = 0; b < beats; b++) begin
        for (int i = 0; i < `STAT_LANES; i++) begin
            data[i] = lcg_next();
        end
        send_beat(data, b == beats - 1);
    end
endtask

task automatic wait_done_pulse();
    int cycles;
    cycles = 0;
    do begin
        @(posedge aclk);
        #1;
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            $display("Timeout waiting for the done pulse");
            stop_with_failure();
        end
    end while (!done);
    check_word("done latency", word_t'(cycles), 32'd6);
endtask

initial begin
    word_t [`STAT_LANES-1:0] lanes;
    aresetn  = 1'b0;
    stream   = '0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    model_clear();
    repeat (3) @(posedge aclk);
    #1;
    check_word("stream_ready in reset", word_t'(stream_ready), 32'd0);
    aresetn = 1'b1;
    @(posedge aclk);
    #1;

    // Reset values
    check_word("stream_ready", word_t'(stream_ready), 32'd1);
    check_word("wb_ack", word_t'(wb_ack), 32'd0);
    check_stats(1'b0);

    // One beat, extremes in separate lanes
    for (int i = 0; i < `STAT_LANES; i++) begin
        lanes[i] = 32'h4000_0000 + word_t'(i) * 32'h0101_0101;
    end
    lanes[11] = 32'h0000_0003;
    lanes[4]  = 32'hFFFF_FFF0;
    send_beat(lanes, 1'b1);
    wait_done_pulse();
    check_stats(1'b1);

    // Several beats in flight, on fresh statistics
    wb_write(`STAT_REG_CTRL, 32'h1);
    model_clear();
    send_random_frame(12);
    wait_done_pulse();
    check_stats(1'b1);

    // Sticky done, unmapped offsets, CTRL without bit 0
    repeat (10) @(posedge aclk);
    #1;
    check_reg("STATUS", `STAT_REG_STATUS, 32'd1);
    check_reg("unmapped read", 8'h20, 32'd0);
    wb_write(8'h14, 32'd1);
    wb_write(`STAT_REG_CTRL, 32'h2);
    check_stats(1'b1);

    // Clear, then a fresh frame
    wb_write(`STAT_REG_CTRL, 32'h1);
    model_clear();
    check_stats(1'b0);
    send_random_frame(5);
    wait_done_pulse();
    check_stats(1'b1);

    $display("Verification passed");
    $finish;
end

endmodule
